//--- fpuPkg.sv
package fpuPkg;

  // csr field widths
  localparam int FrmW    = 3;
  localparam int FflagsW = 5;
  localparam int FcsrW   = FrmW + FflagsW;  // {frm, fflags}

  localparam logic [FrmW-1:0] FrmDyn = 3'b111;  // funct3 value for dynamic rm
  localparam logic [FrmW-1:0] RmMax  = 3'b100;  // rmm is the highest defined mode

  // major opcodes of the fp subset
  typedef enum logic [6:0] {
    opLoadFp  = 7'b0000111,  // flw fld
    opStoreFp = 7'b0100111,  // fsw fsd
    opMadd    = 7'b1000011,
    opMsub    = 7'b1000111,
    opNmsub   = 7'b1001011,
    opNmadd   = 7'b1001111,
    opFp      = 7'b1010011   // everything else, split on funct7
  } fpOpT;

  // writeback source for the fp register file
  typedef enum logic [1:0] {
    resRead    = 2'b00,  // load data
    resFma     = 2'b01,  // fma unit covers add and mul too
    resDivSqrt = 2'b10,
    resMem     = 2'b11   // short ops ready in memory stage
  } fResultSelT;

  // which short op feeds resMem
  typedef enum logic [2:0] {
    selSrcA  = 3'b000,  // plain move
    selSgn   = 3'b001,  // sign injection
    selCmp   = 3'b010,  // min and max
    selCvt   = 3'b011,  // int <-> fp
    selFpFp  = 3'b100   // precision change
  } fResSelT;

  // result toward the integer register file
  typedef enum logic [1:0] {
    intCmp   = 2'b00,  // feq flt fle
    intMove  = 2'b01,  // fmv.x.*
    intClass = 2'b10,
    intCvt   = 2'b11   // fcvt to int
  } fIntResSelT;

  // decoded control, msb first
  typedef struct packed {
    logic             fRegWrite;   // fp regfile write
    logic             fWriteInt;   // int regfile write
    fResultSelT       fResultSel;
    logic [2:0]       fOpCtrl;     // unit specific op code
    fResSelT          fResSel;
    fIntResSelT       fIntResSel;
    logic             fDivStart;   // kicks the div/sqrt unit
    logic             fmt;         // 0 single 1 double
    logic [FrmW-1:0]  frm;         // resolved rounding mode
    logic             illegal;
  } fpuCtrlT;

  localparam int CtrlW = $bits(fpuCtrlT);  // 18

  // empty execute slot
  localparam fpuCtrlT CtrlBubble = fpuCtrlT'({CtrlW{1'b0}});

  // illegal bit is the lsb, all else zero
  localparam fpuCtrlT CtrlIllegal = fpuCtrlT'({{(CtrlW-1){1'b0}}, 1'b1});

  // opCtrl meaning per unit
  //   fma     {is mul, negate product, negate addend}
  //   divsqrt 000 div, 001 sqrt
  //   cmp     {min or max, eq or le, lt or le}
  //   sgn     00 sgnj, 01 sgnjn, 10 sgnjx
  //   cvt     {long, unsigned, to int} per direction
  //   loads   bit 0 is double

endpackage

//--- fctrl.sv
`timescale 1ns/1ps

module fctrl import fpuPkg::*; (
  input  logic [6:0]      funct7,  // instr[31:25], bit 0 is fmt
  input  fpOpT            op,      // instr[6:0]
  input  logic [4:0]      rs2,     // instr[24:20], int width on fcvt
  input  logic [2:0]      funct3,  // rm, or width on load/store
  input  logic [FrmW-1:0] frmReg,  // dynamic rm from csr
  output fpuCtrlT         ctrlD
);

  fpuCtrlT         base;    // table row before fmt and frm
  logic            bad;     // encoding not in table
  logic            rounds;  // instr carries an rm field
  logic [FrmW-1:0] rmRes;   // resolved rounding mode
  logic            rmBad;   // reserved mode on a rounding instr

  // one table row, fields not given stay zero
  function automatic fpuCtrlT ent(
    input logic       regWr,
    input logic       wrInt,
    input fResultSelT resultSel,
    input logic [2:0] opCtrl,
    input fResSelT    resSel,
    input fIntResSelT intResSel
  );
    fpuCtrlT c;
    c            = CtrlBubble;
    c.fRegWrite  = regWr;
    c.fWriteInt  = wrInt;
    c.fResultSel = resultSel;
    c.fOpCtrl    = opCtrl;
    c.fResSel    = resSel;
    c.fIntResSel = intResSel;
    c.fDivStart  = (resultSel == resDivSqrt);  // only fdiv and fsqrt
    return c;
  endfunction

  // main decode table
  always_comb begin
    base = CtrlBubble;
    bad  = 1'b0;
    case (op)
      opLoadFp:
        case (funct3)
          3'b010:  base = ent(1'b1, 1'b0, resRead, 3'b000, selSrcA, intCmp);  // flw
          3'b011:  base = ent(1'b1, 1'b0, resRead, 3'b001, selSrcA, intCmp);  // fld
          default: bad = 1'b1;  // no h or q loads
        endcase
      opStoreFp:
        case (funct3)
          3'b010:  base = ent(1'b0, 1'b0, resRead, 3'b010, selSrcA, intCmp);  // fsw
          3'b011:  base = ent(1'b0, 1'b0, resRead, 3'b011, selSrcA, intCmp);  // fsd
          default: bad = 1'b1;
        endcase
      opMadd:  base = ent(1'b1, 1'b0, resFma, 3'b000, selSrcA, intCmp);  // fmadd
      opMsub:  base = ent(1'b1, 1'b0, resFma, 3'b001, selSrcA, intCmp);  // fmsub
      opNmsub: base = ent(1'b1, 1'b0, resFma, 3'b010, selSrcA, intCmp);  // fnmsub
      opNmadd: base = ent(1'b1, 1'b0, resFma, 3'b011, selSrcA, intCmp);  // fnmadd
      opFp:
        casez (funct7)
          7'b00000??: base = ent(1'b1, 1'b0, resFma, 3'b110, selSrcA, intCmp);  // fadd
          7'b00001??: base = ent(1'b1, 1'b0, resFma, 3'b111, selSrcA, intCmp);  // fsub
          7'b00010??: base = ent(1'b1, 1'b0, resFma, 3'b100, selSrcA, intCmp);  // fmul
          7'b00011??: base = ent(1'b1, 1'b0, resDivSqrt, 3'b000, selSrcA, intCmp);  // fdiv
          7'b01011??: base = ent(1'b1, 1'b0, resDivSqrt, 3'b001, selSrcA, intCmp);  // fsqrt
          7'b00100??:
            case (funct3)
              3'b000:  base = ent(1'b1, 1'b0, resMem, 3'b000, selSgn, intCmp);  // fsgnj
              3'b001:  base = ent(1'b1, 1'b0, resMem, 3'b001, selSgn, intCmp);  // fsgnjn
              3'b010:  base = ent(1'b1, 1'b0, resMem, 3'b010, selSgn, intCmp);  // fsgnjx
              default: bad = 1'b1;
            endcase
          7'b00101??:
            case (funct3)
              3'b000:  base = ent(1'b1, 1'b0, resMem, 3'b111, selCmp, intCmp);  // fmin
              3'b001:  base = ent(1'b1, 1'b0, resMem, 3'b101, selCmp, intCmp);  // fmax
              default: bad = 1'b1;
            endcase
          7'b10100??:
            case (funct3)
              3'b010:  base = ent(1'b0, 1'b1, resMem, 3'b010, selSrcA, intCmp);  // feq
              3'b001:  base = ent(1'b0, 1'b1, resMem, 3'b001, selSrcA, intCmp);  // flt
              3'b000:  base = ent(1'b0, 1'b1, resMem, 3'b011, selSrcA, intCmp);  // fle
              default: bad = 1'b1;
            endcase
          7'b11100??:
            if (funct3 == 3'b001)
              base = ent(1'b0, 1'b1, resMem, 3'b000, selSrcA, intClass);  // fclass
            else if (funct3[1:0] == 2'b00)
              base = ent(1'b0, 1'b1, resMem, 3'b100, selSrcA, intMove);   // fmv.x.w
            else if (funct3[1:0] == 2'b01)
              base = ent(1'b0, 1'b1, resMem, 3'b101, selSrcA, intMove);   // fmv.x.d
            else
              bad = 1'b1;
          7'b110100?:  // int to fp, s and d share op codes
            case (rs2[1:0])
              2'b00: base = ent(1'b1, 1'b0, resMem, 3'b000, selCvt, intCmp);  // from w
              2'b01: base = ent(1'b1, 1'b0, resMem, 3'b010, selCvt, intCmp);  // from wu
              2'b10: base = ent(1'b1, 1'b0, resMem, 3'b100, selCvt, intCmp);  // from l
              2'b11: base = ent(1'b1, 1'b0, resMem, 3'b110, selCvt, intCmp);  // from lu
            endcase
          7'b110000?:  // fp to int
            case (rs2[1:0])
              2'b00: base = ent(1'b0, 1'b1, resMem, 3'b001, selCvt, intCvt);  // to w
              2'b01: base = ent(1'b0, 1'b1, resMem, 3'b011, selCvt, intCvt);  // to wu
              2'b10: base = ent(1'b0, 1'b1, resMem, 3'b101, selCvt, intCvt);  // to l
              2'b11: base = ent(1'b0, 1'b1, resMem, 3'b111, selCvt, intCvt);  // to lu
            endcase
          7'b1111000: base = ent(1'b1, 1'b0, resMem, 3'b000, selSrcA, intCmp);  // fmv.w.x
          7'b1111001: base = ent(1'b1, 1'b0, resMem, 3'b001, selSrcA, intCmp);  // fmv.d.x
          7'b0100000: base = ent(1'b1, 1'b0, resMem, 3'b000, selFpFp, intCmp);  // fcvt.s.d
          default:    bad = 1'b1;  // fcvt.d.s lands here too
        endcase
      default: bad = 1'b1;  // not an fp opcode
    endcase
  end

  // dynamic rm reads the held csr value
  assign rmRes = (funct3 == FrmDyn) ? frmReg : funct3;

  // arithmetic and conversions carry rm, moves and compares do not
  assign rounds = (base.fResultSel inside {resFma, resDivSqrt}) ||
                  (base.fResSel inside {selCvt, selFpFp});

  assign rmBad = rounds && (rmRes > RmMax);  // 101..111 reserved

  always_comb begin
    ctrlD     = base;
    ctrlD.frm = rmRes;
    if (op == opLoadFp || op == opStoreFp)
      ctrlD.fmt = funct3[0];   // w/d width
    else if (base.fResSel == selFpFp)
      ctrlD.fmt = ~funct7[0];  // precision flips on fp to fp
    else
      ctrlD.fmt = funct7[0];
    // any illegal case leaves only the flag
    if (bad || rmBad)
      ctrlD = CtrlIllegal;
  end

endmodule

//--- fpuCsr.sv
`timescale 1ns/1ps

module fpuCsr import fpuPkg::*; (
  input  logic               clk,
  input  logic               rstN,
  input  logic               frmWe,       // csr write to frm
  input  logic [FrmW-1:0]    frmWData,
  input  logic               flagsValid,  // exception flags from execute
  input  logic [FflagsW-1:0] flags,
  output logic [FrmW-1:0]    frmReg,      // held rounding mode
  output logic [FcsrW-1:0]   fcsr
);

  logic [FflagsW-1:0] fflags;  // nx uf of dz nv, sticky

  // rounding mode register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      frmReg <= '0;  // rne
    end else if (frmWe) begin
      frmReg <= frmWData;  // decode sees it next cycle
    end
  end

  // sticky accumulate, only reset clears
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      fflags <= '0;
    end else if (flagsValid) begin
      fflags <= fflags | flags;
    end
  end

  assign fcsr = {frmReg, fflags};  // fcsr[7:5] frm, fcsr[4:0] flags

endmodule

//--- fpuCtrlReg.sv
`timescale 1ns/1ps

module fpuCtrlReg import fpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  logic    instrValid,  // decode slot holds a real instr
  input  logic    stall,       // execute busy, hold
  input  logic    flush,       // kill execute slot
  input  fpuCtrlT ctrlD,
  output fpuCtrlT ctrlE,
  output logic    validE
);

  // decode to execute stage
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctrlE  <= CtrlBubble;
      validE <= 1'b0;
    end else if (flush) begin
      ctrlE  <= CtrlBubble;  // flush beats stall
      validE <= 1'b0;
    end else if (!stall) begin
      if (instrValid) begin
        ctrlE  <= ctrlD;
        validE <= 1'b1;
      end else begin
        ctrlE  <= CtrlBubble;  // nothing to issue
        validE <= 1'b0;
      end
    end
    // stall without flush keeps the slot
  end

endmodule

//--- fpuDecodeTop.sv
`timescale 1ns/1ps

module fpuDecodeTop import fpuPkg::*; (
  input  logic               clk,
  input  logic               rstN,
  input  logic [31:0]        instr,
  input  logic               instrValid,
  input  logic               stall,
  input  logic               flush,
  input  logic               frmWe,
  input  logic [FrmW-1:0]    frmWData,
  input  logic               flagsValid,
  input  logic [FflagsW-1:0] flags,
  output fpuCtrlT            ctrlE,
  output logic               validE,
  output logic [FcsrW-1:0]   fcsr
);

  logic [6:0]      funct7;
  fpOpT            op;
  logic [4:0]      rs2;
  logic [2:0]      funct3;
  logic [FrmW-1:0] frmReg;  // csr to decoder
  fpuCtrlT         ctrlD;   // decoder to stage reg

  // instruction fields, rd and rs1 not needed here
  assign funct7 = instr[31:25];
  assign rs2    = instr[24:20];
  assign funct3 = instr[14:12];
  assign op     = fpOpT'(instr[6:0]);  // unknown codes decode as illegal

  fpuCsr uCsr (
    .clk        (clk),
    .rstN       (rstN),
    .frmWe      (frmWe),
    .frmWData   (frmWData),
    .flagsValid (flagsValid),
    .flags      (flags),
    .frmReg     (frmReg),
    .fcsr       (fcsr)
  );

  fctrl uCtrl (
    .funct7 (funct7),
    .op     (op),
    .rs2    (rs2),
    .funct3 (funct3),
    .frmReg (frmReg),
    .ctrlD  (ctrlD)
  );

  fpuCtrlReg uCtrlReg (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .stall      (stall),
    .flush      (flush),
    .ctrlD      (ctrlD),
    .ctrlE      (ctrlE),
    .validE     (validE)
  );

endmodule

//--- fpuDecodeTb_asserts.sv
`timescale 1ns/1ps

module fpuDecodeTb_asserts import fpuPkg::*; (
  input logic             clk,
  input logic             rstN,
  input fpuCtrlT          ctrlE,
  input logic             validE,
  input logic [FcsrW-1:0] fcsr
);

  int nReset  = 0;  // per rule failure counts
  int nBubble = 0;
  int nFlags  = 0;
  int failCount;    // sum, looked at by the testbench at the end

  logic [FflagsW-1:0] fflagsNow;  // low bits of fcsr

  assign failCount = nReset + nBubble + nFlags;
  assign fflagsNow = fcsr[FflagsW-1:0];

  // no live instr while reset is low
  resetEmpty: assert property (@(posedge clk) !rstN |-> !validE)
    else begin
      nReset++;
      $error("validE high while rstN is low");
    end

  // invalid slot must carry the bubble word
  bubbleZero: assert property (@(posedge clk) disable iff (!rstN)
      !validE |-> (ctrlE == CtrlBubble))
    else begin
      nBubble++;
      $error("ctrlE not a bubble while validE is low");
    end

  // sticky flags, a set bit never drops
  flagsSticky: assert property (@(posedge clk) disable iff (!rstN)
      (($past(fflagsNow) & ~fflagsNow) == '0))
    else begin
      nFlags++;
      $error("an fflags bit was cleared outside reset");
    end

endmodule

bind fpuDecodeTop fpuDecodeTb_asserts rules (
  .clk    (clk),
  .rstN   (rstN),
  .ctrlE  (ctrlE),
  .validE (validE),
  .fcsr   (fcsr)
);

//--- fpuDecodeTb.sv
`timescale 1ns/1ps

module fpuDecodeTb import fpuPkg::*; ();

  localparam int VecWords  = 11;   // hex words per golden line
  localparam int MaxVec    = 64;   // room in the vector memory
  localparam int MaxCycles = 200;  // budget for the whole run

  logic               clk;
  logic               rstN;
  logic [31:0]        instr;
  logic               instrValid;
  logic               stall;
  logic               flush;
  logic               frmWe;
  logic [FrmW-1:0]    frmWData;
  logic               flagsValid;
  logic [FflagsW-1:0] flags;
  fpuCtrlT            ctrlE;
  logic               validE;
  logic [FcsrW-1:0]   fcsr;

  logic [31:0] golden [MaxVec*VecWords];  // flat, one vector per VecWords slots
  int          cycles;                    // negedges seen so far
  int          nVec;                      // vectors found in the file

  fpuDecodeTop uut (
    .clk        (clk),
    .rstN       (rstN),
    .instr      (instr),
    .instrValid (instrValid),
    .stall      (stall),
    .flush      (flush),
    .frmWe      (frmWe),
    .frmWData   (frmWData),
    .flagsValid (flagsValid),
    .flags      (flags),
    .ctrlE      (ctrlE),
    .validE     (validE),
    .fcsr       (fcsr)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // compare one value, stop at the first difference
  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "%s does not match the golden value", name);
    end
  endtask

  // one falling edge, counted against the budget
  task automatic nextNegedge();
    @(negedge clk);
    cycles++;
    if (cycles > MaxCycles) begin
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout, golden vectors not finished within %0d cycles", MaxCycles);
    end
  endtask

  // drive one golden line onto the inputs
  task automatic applyVec(input int v);
    int b;
    b          = v * VecWords;
    instr      = golden[b];
    instrValid = golden[b+1][0];
    stall      = golden[b+2][0];
    flush      = golden[b+3][0];
    frmWe      = golden[b+4][0];
    frmWData   = golden[b+5][FrmW-1:0];
    flagsValid = golden[b+6][0];
    flags      = golden[b+7][FflagsW-1:0];
  endtask

  // outputs one edge after the vector went in
  task automatic checkVec(input int v);
    int b;
    b = v * VecWords;
    checkVal($sformatf("ctrlE vec %0d", v), 32'(ctrlE), golden[b+8]);
    checkVal($sformatf("validE vec %0d", v), 32'(validE), golden[b+9]);
    checkVal($sformatf("fcsr vec %0d", v), 32'(fcsr), golden[b+10]);
  endtask

  initial begin
    // idle inputs, reset held
    rstN       = 1'b0;
    instr      = '0;
    instrValid = 1'b0;
    stall      = 1'b0;
    flush      = 1'b0;
    frmWe      = 1'b0;
    frmWData   = '0;
    flagsValid = 1'b0;
    flags      = '0;
    cycles     = 0;

    // unread slots stay all ones, valid column then reads as end
    for (int i = 0; i < MaxVec*VecWords; i++) begin
      golden[i] = '1;
    end
    $readmemh("fpuGolden.txt", golden);
    nVec = 0;
    while (nVec < MaxVec && golden[nVec*VecWords+1] <= 32'd1) begin
      nVec++;
    end
    if (nVec == 0) begin
      $display("*** TEST FAILED ***");
      $fatal(1, "golden file gave no vectors");
    end

    repeat (5) nextNegedge();  // reset for 5 cycles
    rstN = 1'b1;
    nextNegedge();

    // empty slot and clear csr out of reset
    checkVal("ctrlE after reset", 32'(ctrlE), 32'h0);
    checkVal("validE after reset", 32'(validE), 32'h0);
    checkVal("fcsr after reset", 32'(fcsr), 32'h0);

    for (int v = 0; v < nVec; v++) begin
      applyVec(v);
      nextNegedge();  // rising edge in between captures it
      checkVec(v);
    end

    if (uut.rules.failCount == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("*** TEST FAILED ***");
      $fatal(1, "%0d concurrent assertion failures", uut.rules.failCount);
    end
  end

endmodule

//--- fpuGolden.txt
// instr instrValid stall flush frmWe frmWData flagsValid flags
// then expected ctrlE validE fcsr, one cycle after the line is applied
00002007 1 0 0 0 0 0 00 20004 1 00
00003027 1 0 0 0 0 0 00 01816 1 00
02001043 1 0 0 0 0 0 00 24012 1 00
00000053 1 0 0 0 0 0 00 27000 1 00
1a007053 1 0 0 1 3 0 00 28030 1 60
58007053 1 0 0 0 0 1 01 28826 1 61
22002053 1 0 0 0 0 1 04 2d114 1 65
28001053 1 0 0 0 0 1 01 2ea02 1 65
a2001053 1 0 0 0 0 0 00 1c812 1 65
e0001053 1 0 0 0 0 0 00 1c082 1 65
e2000053 1 0 0 0 0 0 00 1e050 1 65
c2201053 1 0 0 0 0 0 00 1ebd2 1 65
40100053 1 0 0 0 0 0 00 2c410 1 65
02005053 1 0 0 1 6 0 00 00001 1 c5
10007053 1 0 0 1 4 0 00 00001 1 85
10007053 1 0 0 0 0 0 00 26008 1 85
00000033 1 0 0 0 0 0 00 00001 1 85
00001007 1 0 0 0 0 0 00 00001 1 85
60000053 1 0 0 0 0 0 00 00001 1 85
00000053 1 0 0 0 0 0 00 27000 1 85
08000053 1 1 0 0 0 0 00 27000 1 85
08000053 1 0 0 0 0 0 00 27800 1 85
10000053 1 1 1 0 0 0 00 00000 0 85
10000053 1 0 0 0 0 0 00 26000 1 85
10000053 0 0 0 0 0 1 10 00000 0 95
00000000 0 1 0 0 0 1 08 00000 0 9d
a0000053 1 0 0 1 2 0 02 1d800 1 5d
18007053 1 0 0 0 0 1 00 28024 1 5d
00000000 0 0 0 0 0 1 02 00000 0 5f

//--- flist.f
fpuPkg.sv
fctrl.sv
fpuCsr.sv
fpuCtrlReg.sv
fpuDecodeTop.sv
fpuDecodeTb_asserts.sv
fpuDecodeTb.sv

//--- Makefile
TOP = fpuDecodeTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
